// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// bus geometry
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// byte address to word index
	localparam int ADDR_LSH = 2;

	// main RAM, 4 KiB
	localparam logic [ADDR_WIDTH-1:0] RAM_BASE = 32'h0000_0000;
	localparam int RAM_WORDS = 1024;
	localparam logic [ADDR_WIDTH-1:0] RAM_BYTES = ADDR_WIDTH'(RAM_WORDS << ADDR_LSH);

	// scratch RAM, 256 bytes
	localparam logic [ADDR_WIDTH-1:0] SCRATCH_BASE = 32'h0001_0000;
	localparam int SCRATCH_WORDS = 64;
	localparam logic [ADDR_WIDTH-1:0] SCRATCH_BYTES =
		ADDR_WIDTH'(SCRATCH_WORDS << ADDR_LSH);

	// what the main RAM holds once its wipe is done
	localparam logic [DATA_WIDTH-1:0] FILL_WORD = 32'hDEAD_0000;

endpackage

`default_nettype wire

// ==== hdl/bram.sv ====
`default_nettype none

module bram #(
	parameter int WIDTH = 32,
	parameter int SIZE = 1024,
	parameter bit CLEAR = 1'b0,
	parameter logic [WIDTH-1:0] CLEAR_VALUE = '0,
	parameter int LATENCY = 0
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire i_rw,
	input wire [mem_pkg::ADDR_WIDTH-1:0] i_address,
	input wire [WIDTH-1:0] i_wdata,
	output logic [WIDTH-1:0] o_rdata,
	output logic o_ready,
	output logic o_initialized
);

	localparam int IDX_W = (SIZE > 1) ? $clog2(SIZE) : 1;
	localparam int CNT_W = $clog2(LATENCY + 2);

	logic [WIDTH-1:0] mem [SIZE];

	logic [IDX_W-1:0] index;
	logic [CNT_W-1:0] run_count;
	logic access;

	logic wipe_en;
	logic [IDX_W-1:0] wipe_index;

	logic mem_we;
	logic [IDX_W-1:0] mem_waddr;
	logic [WIDTH-1:0] mem_wdata;

	// address arrives as a word index, already bank relative
	assign index = i_address[IDX_W-1:0];

	// only the first cycle of a request run touches the array
	assign access = i_request && o_initialized && (run_count == '0);

	if (CLEAR) begin : g_wipe
		logic [IDX_W:0] clear_count;

		always_ff @(posedge i_clock) begin
			if (i_reset) begin
				clear_count <= '0;
			end else if (!o_initialized) begin
				clear_count <= clear_count + 1'b1;
			end
		end

		assign o_initialized = (clear_count >= SIZE);
		assign wipe_en = !o_initialized && !i_reset;
		assign wipe_index = clear_count[IDX_W-1:0];
	end else begin : g_no_wipe
		assign o_initialized = 1'b1;
		assign wipe_en = 1'b0;
		assign wipe_index = '0;
	end

	// one write port, shared by the wipe and by bus writes
	always_comb begin
		if (wipe_en) begin
			mem_we = 1'b1;
			mem_waddr = wipe_index;
			mem_wdata = CLEAR_VALUE;
		end else begin
			mem_we = access && i_rw;
			mem_waddr = index;
			mem_wdata = i_wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (mem_we) begin
			mem[mem_waddr] <= mem_wdata;
		end
		if (access && !i_rw) begin
			o_rdata <= mem[index];
		end
	end

	// run length of the current request, stops at LATENCY+1
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			run_count <= '0;
			o_ready <= 1'b0;
		end else begin
			if (!(i_request && o_initialized)) begin
				run_count <= '0;
			end else if (run_count <= LATENCY) begin
				run_count <= run_count + 1'b1;
			end
			o_ready <= i_request && o_initialized && (run_count >= LATENCY);
		end
	end

	// no handshake may complete before the wipe is done
	ready_after_init: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_ready |-> o_initialized
	);

endmodule

`default_nettype wire

// ==== hdl/bram_wb_slave.sv ====
`default_nettype none

module bram_wb_slave (
	input wire i_clock,
	input wire i_reset,

	// wishbone classic, from the bank decoder
	input wire i_wb_cyc,
	input wire i_wb_stb,
	input wire i_wb_we,
	input wire [mem_pkg::ADDR_WIDTH-1:0] i_wb_adr,
	input wire [mem_pkg::DATA_WIDTH-1:0] i_wb_dat,
	output logic [mem_pkg::DATA_WIDTH-1:0] o_wb_dat,
	output logic o_wb_ack,

	// request/ready, to the bram
	output logic o_request,
	output logic o_rw,
	output logic [mem_pkg::ADDR_WIDTH-1:0] o_address,
	output logic [mem_pkg::DATA_WIDTH-1:0] o_wdata,
	input wire [mem_pkg::DATA_WIDTH-1:0] i_rdata,
	input wire i_ready
);

	logic cycle_active;

	assign cycle_active = i_wb_cyc && i_wb_stb;

	// request follows the held strobe but drops in the ready cycle,
	// so the bram run counter restarts and a write lands only once
	assign o_request = cycle_active && !i_ready;

	assign o_rw = i_wb_we;
	assign o_address = i_wb_adr;
	assign o_wdata = i_wb_dat;

	// a ready left over from an aborted cycle is not passed on
	assign o_wb_ack = i_ready && cycle_active;
	assign o_wb_dat = i_rdata;

	// ack only for a cycle that was already presented a clock earlier
	ack_in_cycle: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_wb_ack |-> $past(cycle_active)
	);

endmodule

`default_nettype wire

// ==== hdl/wb_bank_decoder.sv ====
`default_nettype none

module wb_bank_decoder (
	input wire i_clock,
	input wire i_reset,

	// external slave port
	input wire i_wb_cyc,
	input wire i_wb_stb,
	input wire i_wb_we,
	input wire [mem_pkg::ADDR_WIDTH-1:0] i_wb_adr,
	input wire [mem_pkg::DATA_WIDTH-1:0] i_wb_dat,
	output logic [mem_pkg::DATA_WIDTH-1:0] o_wb_dat,
	output logic o_wb_ack,
	output logic o_wb_err,

	// main RAM bank
	output logic o_ram_stb,
	output logic o_ram_we,
	output logic [mem_pkg::ADDR_WIDTH-1:0] o_ram_adr,
	output logic [mem_pkg::DATA_WIDTH-1:0] o_ram_dat,
	input wire i_ram_ack,
	input wire [mem_pkg::DATA_WIDTH-1:0] i_ram_dat,

	// scratch RAM bank
	output logic o_scratch_stb,
	output logic o_scratch_we,
	output logic [mem_pkg::ADDR_WIDTH-1:0] o_scratch_adr,
	output logic [mem_pkg::DATA_WIDTH-1:0] o_scratch_dat,
	input wire i_scratch_ack,
	input wire [mem_pkg::DATA_WIDTH-1:0] i_scratch_dat
);

	logic cycle_active;
	logic [mem_pkg::ADDR_WIDTH-1:0] ram_offset;
	logic [mem_pkg::ADDR_WIDTH-1:0] scratch_offset;
	logic ram_hit;
	logic scratch_hit;

	assign cycle_active = i_wb_cyc && i_wb_stb;

	// an address below a base wraps to a large offset and misses
	assign ram_offset = i_wb_adr - mem_pkg::RAM_BASE;
	assign scratch_offset = i_wb_adr - mem_pkg::SCRATCH_BASE;
	assign ram_hit = ram_offset < mem_pkg::RAM_BYTES;
	assign scratch_hit = scratch_offset < mem_pkg::SCRATCH_BYTES;

	assign o_ram_stb = cycle_active && ram_hit;
	assign o_ram_we = i_wb_we;
	assign o_ram_adr = ram_offset >> mem_pkg::ADDR_LSH;
	assign o_ram_dat = i_wb_dat;

	assign o_scratch_stb = cycle_active && scratch_hit;
	assign o_scratch_we = i_wb_we;
	assign o_scratch_adr = scratch_offset >> mem_pkg::ADDR_LSH;
	assign o_scratch_dat = i_wb_dat;

	// return path follows the decoded bank
	always_comb begin
		if (ram_hit) begin
			o_wb_ack = i_ram_ack;
		end else if (scratch_hit) begin
			o_wb_ack = i_scratch_ack;
		end else begin
			o_wb_ack = 1'b0;
		end
	end

	assign o_wb_dat = scratch_hit ? i_scratch_dat : i_ram_dat;

	// unmapped: one err pulse a clock after stb, no bank sees the cycle
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_wb_err <= 1'b0;
		end else begin
			o_wb_err <= cycle_active && !ram_hit && !scratch_hit && !o_wb_err;
		end
	end

	ack_err_exclusive: assert property (
		@(posedge i_clock) disable iff (i_reset)
		!(o_wb_ack && o_wb_err)
	);

endmodule

`default_nettype wire

// ==== hdl/mem_subsystem.sv ====
`default_nettype none

module mem_subsystem #(
	parameter int SCRATCH_LATENCY = 2
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_wb_cyc,
	input wire i_wb_stb,
	input wire i_wb_we,
	input wire [mem_pkg::ADDR_WIDTH-1:0] i_wb_adr,
	input wire [mem_pkg::DATA_WIDTH-1:0] i_wb_dat,
	output logic [mem_pkg::DATA_WIDTH-1:0] o_wb_dat,
	output logic o_wb_ack,
	output logic o_wb_err,
	output logic o_initialized
);

	// decoder to main RAM adapter
	logic ram_stb;
	logic ram_we;
	logic [mem_pkg::ADDR_WIDTH-1:0] ram_adr;
	logic [mem_pkg::DATA_WIDTH-1:0] ram_wb_wdat;
	logic ram_ack;
	logic [mem_pkg::DATA_WIDTH-1:0] ram_wb_rdat;

	// main RAM adapter to bram
	logic ram_request;
	logic ram_rw;
	logic [mem_pkg::ADDR_WIDTH-1:0] ram_address;
	logic [mem_pkg::DATA_WIDTH-1:0] ram_wdata;
	logic [mem_pkg::DATA_WIDTH-1:0] ram_rdata;
	logic ram_ready;

	// decoder to scratch adapter
	logic scratch_stb;
	logic scratch_we;
	logic [mem_pkg::ADDR_WIDTH-1:0] scratch_adr;
	logic [mem_pkg::DATA_WIDTH-1:0] scratch_wb_wdat;
	logic scratch_ack;
	logic [mem_pkg::DATA_WIDTH-1:0] scratch_wb_rdat;

	// scratch adapter to bram
	logic scratch_request;
	logic scratch_rw;
	logic [mem_pkg::ADDR_WIDTH-1:0] scratch_address;
	logic [mem_pkg::DATA_WIDTH-1:0] scratch_wdata;
	logic [mem_pkg::DATA_WIDTH-1:0] scratch_rdata;
	logic scratch_ready;

	wb_bank_decoder decoder_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat),
		.o_wb_ack(o_wb_ack),
		.o_wb_err(o_wb_err),
		.o_ram_stb(ram_stb),
		.o_ram_we(ram_we),
		.o_ram_adr(ram_adr),
		.o_ram_dat(ram_wb_wdat),
		.i_ram_ack(ram_ack),
		.i_ram_dat(ram_wb_rdat),
		.o_scratch_stb(scratch_stb),
		.o_scratch_we(scratch_we),
		.o_scratch_adr(scratch_adr),
		.o_scratch_dat(scratch_wb_wdat),
		.i_scratch_ack(scratch_ack),
		.i_scratch_dat(scratch_wb_rdat)
	);

	bram_wb_slave ram_slave_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(ram_stb),
		.i_wb_we(ram_we),
		.i_wb_adr(ram_adr),
		.i_wb_dat(ram_wb_wdat),
		.o_wb_dat(ram_wb_rdat),
		.o_wb_ack(ram_ack),
		.o_request(ram_request),
		.o_rw(ram_rw),
		.o_address(ram_address),
		.o_wdata(ram_wdata),
		.i_rdata(ram_rdata),
		.i_ready(ram_ready)
	);

	// main RAM wipes itself after every reset
	bram #(
		.WIDTH(mem_pkg::DATA_WIDTH),
		.SIZE(mem_pkg::RAM_WORDS),
		.CLEAR(1'b1),
		.CLEAR_VALUE(mem_pkg::FILL_WORD),
		.LATENCY(0)
	) ram_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(ram_request),
		.i_rw(ram_rw),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready),
		.o_initialized(o_initialized)
	);

	bram_wb_slave scratch_slave_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(scratch_stb),
		.i_wb_we(scratch_we),
		.i_wb_adr(scratch_adr),
		.i_wb_dat(scratch_wb_wdat),
		.o_wb_dat(scratch_wb_rdat),
		.o_wb_ack(scratch_ack),
		.o_request(scratch_request),
		.o_rw(scratch_rw),
		.o_address(scratch_address),
		.o_wdata(scratch_wdata),
		.i_rdata(scratch_rdata),
		.i_ready(scratch_ready)
	);

	// scratch has no wipe, so it is ready from reset on
	bram #(
		.WIDTH(mem_pkg::DATA_WIDTH),
		.SIZE(mem_pkg::SCRATCH_WORDS),
		.CLEAR(1'b0),
		.CLEAR_VALUE(mem_pkg::FILL_WORD),
		.LATENCY(SCRATCH_LATENCY)
	) scratch_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(scratch_request),
		.i_rw(scratch_rw),
		.i_address(scratch_address),
		.i_wdata(scratch_wdata),
		.o_rdata(scratch_rdata),
		.o_ready(scratch_ready),
		.o_initialized()
	);

endmodule

`default_nettype wire

// ==== dv/mem_ref_model.svh ====
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

typedef enum int {
	BANK_MAIN,
	BANK_SCRATCH,
	BANK_NONE
} bank_e;

// expected contents of both banks
logic [mem_pkg::DATA_WIDTH-1:0] main_words [mem_pkg::RAM_WORDS];
logic [mem_pkg::DATA_WIDTH-1:0] scratch_words [mem_pkg::SCRATCH_WORDS];
bit scratch_written [mem_pkg::SCRATCH_WORDS];

// a bank covers its base up to base plus its size in bytes
function automatic bank_e bank_of(input logic [mem_pkg::ADDR_WIDTH-1:0] adr);
	longint unsigned main_end;
	longint unsigned scratch_end;
	main_end = longint'(mem_pkg::RAM_BASE) + longint'(mem_pkg::RAM_WORDS) * 4;
	scratch_end = longint'(mem_pkg::SCRATCH_BASE) + longint'(mem_pkg::SCRATCH_WORDS) * 4;
	if (adr >= mem_pkg::RAM_BASE && adr < main_end) begin
		return BANK_MAIN;
	end
	if (adr >= mem_pkg::SCRATCH_BASE && adr < scratch_end) begin
		return BANK_SCRATCH;
	end
	return BANK_NONE;
endfunction

function automatic int word_index(input logic [mem_pkg::ADDR_WIDTH-1:0] adr);
	if (bank_of(adr) == BANK_SCRATCH) begin
		return int'((adr - mem_pkg::SCRATCH_BASE) / 4);
	end
	return int'((adr - mem_pkg::RAM_BASE) / 4);
endfunction

// main RAM as the hardware wipe leaves it
task automatic wipe_main_ram();
	foreach (main_words[i]) begin
		main_words[i] = mem_pkg::FILL_WORD;
	end
endtask

task automatic clear_scratch_flags();
	foreach (scratch_written[i]) begin
		scratch_written[i] = 1'b0;
	end
endtask

task automatic store_word(input logic [mem_pkg::ADDR_WIDTH-1:0] adr,
		input logic [mem_pkg::DATA_WIDTH-1:0] data);
	if (bank_of(adr) == BANK_MAIN) begin
		main_words[word_index(adr)] = data;
	end else if (bank_of(adr) == BANK_SCRATCH) begin
		scratch_words[word_index(adr)] = data;
		scratch_written[word_index(adr)] = 1'b1;
	end
endtask

// known is low for unmapped addresses and unwritten scratch words
task automatic load_word(input logic [mem_pkg::ADDR_WIDTH-1:0] adr,
		output logic [mem_pkg::DATA_WIDTH-1:0] data, output bit known);
	data = 'x;
	known = 1'b0;
	if (bank_of(adr) == BANK_MAIN) begin
		data = main_words[word_index(adr)];
		known = 1'b1;
	end else if (bank_of(adr) == BANK_SCRATCH) begin
		data = scratch_words[word_index(adr)];
		known = scratch_written[word_index(adr)];
	end
endtask

`endif

// ==== dv/mem_subsystem_tb.sv ====
`default_nettype none

module mem_subsystem_tb;

	localparam int SCRATCH_LATENCY = 2;
	localparam int RESET_CYCLES = 16;
	localparam int WIPE_READS = 40;
	localparam int MAIN_CYCLES = 40;
	localparam int SCRATCH_CYCLES = 60;
	localparam int UNMAPPED_ROUNDS = 12;
	localparam int B2B_CYCLES = 100;
	localparam int RESET_READS = 20;
	// an unmapped round is three cycles, the reset phase adds one waiting read
	localparam int TRANSACTIONS = WIPE_READS + 2 * MAIN_CYCLES + SCRATCH_CYCLES +
		3 * UNMAPPED_ROUNDS + B2B_CYCLES + 1 + 2 * RESET_READS;
	localparam int TIMEOUT_CLOCKS = TRANSACTIONS * (SCRATCH_LATENCY + 3) +
		2 * mem_pkg::RAM_WORDS + 200;

	logic clock;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [mem_pkg::ADDR_WIDTH-1:0] wb_adr;
	logic [mem_pkg::DATA_WIDTH-1:0] wb_wdat;
	logic [mem_pkg::DATA_WIDTH-1:0] wb_rdat;
	logic wb_ack;
	logic wb_err;
	logic initialized;

	int seed = 43219;
	int data_errors = 0;
	int timing_errors = 0;
	int protocol_errors = 0;
	logic [mem_pkg::ADDR_WIDTH-1:0] adr;
	logic [mem_pkg::DATA_WIDTH-1:0] expected;
	bit known;
	// main RAM addresses written in the write phase
	logic [mem_pkg::ADDR_WIDTH-1:0] main_written [$];

	`include "mem_ref_model.svh"

	mem_subsystem #(
		.SCRATCH_LATENCY(SCRATCH_LATENCY)
	) dut_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_wb_cyc(wb_cyc),
		.i_wb_stb(wb_stb),
		.i_wb_we(wb_we),
		.i_wb_adr(wb_adr),
		.i_wb_dat(wb_wdat),
		.o_wb_dat(wb_rdat),
		.o_wb_ack(wb_ack),
		.o_wb_err(wb_err),
		.o_initialized(initialized)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		repeat (TIMEOUT_CLOCKS) @(posedge clock);
		$display("run timed out after %0d clocks", TIMEOUT_CLOCKS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	function automatic logic [mem_pkg::DATA_WIDTH-1:0] random_word();
		return $random(seed);
	endfunction

	function automatic bit random_bit();
		logic [mem_pkg::DATA_WIDTH-1:0] w;
		w = random_word();
		return w[0];
	endfunction

	function automatic logic [mem_pkg::ADDR_WIDTH-1:0] main_address();
		return mem_pkg::RAM_BASE + (random_word() % mem_pkg::RAM_WORDS) * 4;
	endfunction

	function automatic logic [mem_pkg::ADDR_WIDTH-1:0] scratch_address();
		return mem_pkg::SCRATCH_BASE + (random_word() % mem_pkg::SCRATCH_WORDS) * 4;
	endfunction

	// mostly just past or just before a bank, sometimes anywhere
	function automatic logic [mem_pkg::ADDR_WIDTH-1:0] unmapped_address();
		logic [mem_pkg::ADDR_WIDTH-1:0] a;
		case (random_word() % 4)
			0: a = mem_pkg::RAM_BASE + mem_pkg::RAM_WORDS * 4 + (random_word() % 16) * 4;
			1: a = mem_pkg::SCRATCH_BASE - (random_word() % 16 + 1) * 4;
			2: a = mem_pkg::SCRATCH_BASE + mem_pkg::SCRATCH_WORDS * 4 + (random_word() % 16) * 4;
			default: a = random_word() & ~32'h3;
		endcase
		while (bank_of(a) != BANK_NONE) begin
			a = random_word() & ~32'h3;
		end
		return a;
	endfunction

	task automatic apply_reset();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		assert (!wb_ack && !wb_err && !initialized && !dut_i.ram_request &&
				!dut_i.scratch_request) else begin
			protocol_errors++;
			$display("reset left ack, err, a request or initialized high");
		end
		reset = 1'b0;
	endtask

	task automatic wait_for_wipe(input string test);
		int clocks;
		clocks = 0;
		while (!initialized) begin
			@(negedge clock);
			clocks++;
		end
		assert (clocks == mem_pkg::RAM_WORDS) else begin
			timing_errors++;
			$display("ERROR %s wipe time: expected %0d, actual %0d", test,
				mem_pkg::RAM_WORDS, clocks);
		end
	endtask

	// one classic cycle, started and finished on a falling edge
	task automatic run_cycle(input string test, input bit we,
			input logic [mem_pkg::ADDR_WIDTH-1:0] cyc_adr,
			input logic [mem_pkg::DATA_WIDTH-1:0] wdata,
			input int expected_wait, input bit idle_after);
		logic [mem_pkg::DATA_WIDTH-1:0] model_data;
		bit model_known;
		bank_e bank;
		int waited;
		bank = bank_of(cyc_adr);
		load_word(cyc_adr, model_data, model_known);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = cyc_adr;
		wb_wdat = wdata;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!wb_ack && !wb_err);
		if (bank == BANK_NONE) begin
			assert (wb_err && !wb_ack) else begin
				protocol_errors++;
				$display("%s: unmapped address %h was acknowledged", test, cyc_adr);
			end
		end else begin
			assert (wb_ack && !wb_err && (bank != BANK_MAIN || initialized)) else begin
				protocol_errors++;
				$display("%s: address %h did not end with a clean ack", test, cyc_adr);
			end
		end
		if (expected_wait > 0) begin
			assert (waited == expected_wait) else begin
				timing_errors++;
				$display("ERROR %s latency at %h: expected %0d, actual %0d", test, cyc_adr,
					expected_wait, waited);
			end
		end
		if (!we && model_known) begin
			assert (wb_rdat === model_data) else begin
				data_errors++;
				$display("ERROR %s read at %h: expected %h, actual %h", test, cyc_adr,
					model_data, wb_rdat);
			end
		end
		if (we) begin
			store_word(cyc_adr, wdata);
		end
		if (idle_after) begin
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we = 1'b0;
			@(negedge clock);
		end
	endtask

	initial begin
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdat = '0;
		wipe_main_ram();
		clear_scratch_flags();
		apply_reset();
		wait_for_wipe("wipe");
		repeat (WIPE_READS) run_cycle("wipe", 1'b0, main_address(), '0, 1, 1'b1);
		repeat (MAIN_CYCLES) begin
			adr = main_address();
			main_written.push_back(adr);
			run_cycle("main_rw", 1'b1, adr, random_word(), 1, 1'b1);
		end
		// read back from the written words so each read meets a stored value
		repeat (MAIN_CYCLES) begin
			adr = main_written[random_word() % main_written.size()];
			run_cycle("main_rw", 1'b0, adr, '0, 1, 1'b1);
		end
		// a read of an unwritten scratch word turns into a write
		repeat (SCRATCH_CYCLES) begin
			adr = scratch_address();
			load_word(adr, expected, known);
			run_cycle("scratch", !known || random_bit(), adr, random_word(),
				SCRATCH_LATENCY + 1, 1'b1);
		end
		repeat (UNMAPPED_ROUNDS) begin
			adr = unmapped_address();
			run_cycle("unmapped", random_bit(), adr, random_word(), 1, 1'b1);
			run_cycle("unmapped", 1'b0, mem_pkg::RAM_BASE + adr % (mem_pkg::RAM_WORDS * 4),
				'0, 1, 1'b1);
			run_cycle("unmapped", 1'b0,
				mem_pkg::SCRATCH_BASE + adr % (mem_pkg::SCRATCH_WORDS * 4),
				'0, SCRATCH_LATENCY + 1, 1'b1);
		end
		for (int i = 0; i < B2B_CYCLES; i++) begin
			case (random_word() % 3)
				0: adr = main_address();
				1: adr = scratch_address();
				default: adr = unmapped_address();
			endcase
			run_cycle("back_to_back", random_bit(), adr, random_word(), 0, i == B2B_CYCLES - 1);
		end
		// scratch keeps its contents, main RAM wipes again
		apply_reset();
		wipe_main_ram();
		// words written before the reset must show the fill value again
		adr = main_written[random_word() % main_written.size()];
		run_cycle("reset_mid_run", 1'b0, adr, '0, mem_pkg::RAM_WORDS + 1, 1'b1);
		repeat (RESET_READS) begin
			adr = main_written[random_word() % main_written.size()];
			run_cycle("reset_mid_run", 1'b0, adr, '0, 1, 1'b1);
		end
		repeat (RESET_READS) begin
			adr = scratch_address();
			load_word(adr, expected, known);
			if (known) begin
				run_cycle("reset_mid_run", 1'b0, adr, '0, SCRATCH_LATENCY + 1, 1'b1);
			end
		end
		$display("errors: data %0d, timing %0d, protocol %0d", data_errors, timing_errors,
			protocol_errors);
		if (data_errors + timing_errors + protocol_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+dv
hdl/mem_pkg.sv
hdl/bram.sv
hdl/bram_wb_slave.sv
hdl/wb_bank_decoder.sv
hdl/mem_subsystem.sv
dv/mem_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - files:
      - hdl/mem_pkg.sv
      - hdl/bram.sv
      - hdl/bram_wb_slave.sv
      - hdl/wb_bank_decoder.sv
      - hdl/mem_subsystem.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mem_subsystem_tb.sv
